// ==== common/mxint_pkg.sv ====
// MXINT shared definitions
// Widths, block shape and packed block types for the block floating point
// linear layer. Every block carries signed mantissas and one shared exponent.
`default_nettype none

package mxint_pkg;

  // Block shape
  localparam int BLOCK_IN = 4;
  localparam int BLOCK_OUT = 2;
  localparam int MAX_IN_DEPTH = 16;

  // Input precision
  localparam int MAN_WIDTH = 8;
  localparam int EXP_WIDTH = 5;

  // Internal precision, products and accumulation
  localparam int PROD_WIDTH = 2 * MAN_WIDTH + 2;
  localparam int ACC_WIDTH = PROD_WIDTH + $clog2(MAX_IN_DEPTH);
  localparam int SUM_WIDTH = ACC_WIDTH + 1;
  localparam int ACC_EXP_WIDTH = EXP_WIDTH + 1;

  // Output precision
  localparam int OUT_MAN_WIDTH = 8;
  localparam int OUT_EXP_WIDTH = 6;

  typedef logic signed [MAN_WIDTH-1:0] man_t;
  typedef logic signed [EXP_WIDTH-1:0] exp_t;
  typedef logic signed [PROD_WIDTH-1:0] prod_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;
  typedef logic signed [SUM_WIDTH-1:0] sum_t;
  typedef logic signed [ACC_EXP_WIDTH-1:0] acc_exp_t;
  typedef logic signed [OUT_MAN_WIDTH-1:0] out_man_t;
  typedef logic signed [OUT_EXP_WIDTH-1:0] out_exp_t;

  // One row of input mantissas, also one row of a weight block
  typedef man_t [BLOCK_IN-1:0] in_row_t;

  typedef struct packed {
    in_row_t man;
    exp_t    exp;
  } data_block_t;

  typedef struct packed {
    in_row_t [BLOCK_OUT-1:0] man;
    exp_t                    exp;
  } weight_block_t;

  typedef struct packed {
    man_t [BLOCK_OUT-1:0] man;
    exp_t                 exp;
  } bias_block_t;

  typedef struct packed {
    prod_t [BLOCK_OUT-1:0] man;
    acc_exp_t              exp;
  } prod_block_t;

  // After accumulation and after the bias add
  typedef struct packed {
    sum_t [BLOCK_OUT-1:0] man;
    acc_exp_t             exp;
  } acc_block_t;

  typedef struct packed {
    out_man_t [BLOCK_OUT-1:0] man;
    out_exp_t                 exp;
  } out_block_t;

endpackage

`default_nettype wire

// ==== src/mxint_circular.sv ====
// Replay buffer for MXINT blocks
// Fills a register array with BUFFER_SIZE blocks, then plays the whole
// array back REPEAT times before it accepts a new fill.
`default_nettype none

module mxint_circular #(
  parameter int BUFFER_SIZE = 4,
  parameter int REPEAT = 2,
  parameter type block_t = logic [7:0]
) (
  input  wire    clk,
  input  wire    reset,
  input  wire    block_t in_block,
  input  wire    in_valid,
  output logic   in_ready,
  output block_t out_block,
  output logic   out_valid,
  input  wire    out_ready
);

  localparam int ADDR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
  localparam int PASS_W = (REPEAT > 1) ? $clog2(REPEAT) : 1;

  typedef enum logic {
    st_fill,
    st_replay
  } state_t;

  state_t state;
  block_t mem [BUFFER_SIZE];
  logic [ADDR_W-1:0] addr;
  logic [PASS_W-1:0] pass;
  logic last_addr;

  assign in_ready = (state == st_fill);
  assign out_valid = (state == st_replay);
  assign out_block = mem[addr];
  assign last_addr = (addr == ADDR_W'(BUFFER_SIZE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fill;
      addr <= '0;
      pass <= '0;
    end else if (state == st_fill) begin
      if (in_valid) begin
        if (last_addr) begin
          addr <= '0;
          pass <= '0;
          state <= st_replay;
        end else begin
          addr <= addr + 1'b1;
        end
      end
    end else if (out_ready) begin
      if (last_addr) begin
        addr <= '0;
        // End of one pass over the stored run
        if (pass == PASS_W'(REPEAT - 1)) begin
          state <= st_fill;
        end else begin
          pass <= pass + 1'b1;
        end
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

  // Storage only
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      mem[addr] <= in_block;
    end
  end

endmodule

`default_nettype wire

// ==== src/mxint_dot_product.sv ====
// MXINT dot product for one output feature
// Multiplies four signed mantissa pairs, sums them and adds the two block
// exponents. One register stage with valid/ready handshake.
`default_nettype none

module mxint_dot_product (
  input  wire                    clk,
  input  wire                    reset,
  input  wire mxint_pkg::data_block_t data,
  input  wire mxint_pkg::in_row_t     weight_row,
  input  wire mxint_pkg::exp_t        weight_exp,
  input  wire                    in_valid,
  output logic                   in_ready,
  output mxint_pkg::prod_t       product,
  output mxint_pkg::acc_exp_t    product_exp,
  output logic                   out_valid,
  input  wire                    out_ready
);

  import mxint_pkg::*;

  prod_t sum;
  acc_exp_t exp_sum;

  // Stage takes a new input when empty or being emptied
  assign in_ready = !out_valid || out_ready;

  always_comb begin
    sum = '0;
    for (int i = 0; i < BLOCK_IN; i++) begin
      sum = sum + prod_t'(data.man[i]) * prod_t'(weight_row[i]);
    end
  end

  // Shared exponent of the product block
  assign exp_sum = acc_exp_t'(data.exp) + acc_exp_t'(weight_exp);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      product <= sum;
      product_exp <= exp_sum;
    end
  end

endmodule

`default_nettype wire

// ==== src/mxint_accumulator.sv ====
// MXINT block accumulator
// Adds IN_DEPTH product blocks along the input dimension. Before each add
// the side with the smaller exponent is shifted right to the larger one.
// The finished block is held until the consumer takes it.
`default_nettype none

module mxint_accumulator #(
  parameter int IN_DEPTH = 2
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire mxint_pkg::prod_block_t in_block,
  input  wire                         in_valid,
  output logic                        in_ready,
  output mxint_pkg::acc_block_t       acc,
  output logic                        out_valid,
  input  wire                         out_ready
);

  import mxint_pkg::*;

  localparam int CNT_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

  logic [CNT_W-1:0] count;
  acc_t acc_man [BLOCK_OUT];
  acc_exp_t acc_exp;
  logic in_fire;
  logic signed [ACC_EXP_WIDTH:0] exp_diff;
  logic [ACC_EXP_WIDTH:0] shift_amt;
  acc_t next_man [BLOCK_OUT];
  acc_exp_t next_exp;

  assign in_ready = !out_valid || out_ready;
  assign in_fire = in_valid && in_ready;

  // Align to the larger exponent, truncating the other side
  always_comb begin
    exp_diff = $signed(in_block.exp) - $signed(acc_exp);
    shift_amt = exp_diff[ACC_EXP_WIDTH] ? -exp_diff : exp_diff;
    next_exp = exp_diff[ACC_EXP_WIDTH] ? acc_exp : in_block.exp;
    for (int i = 0; i < BLOCK_OUT; i++) begin
      if (exp_diff[ACC_EXP_WIDTH]) begin
        next_man[i] = acc_man[i] + (acc_t'(in_block.man[i]) >>> shift_amt);
      end else begin
        next_man[i] = (acc_man[i] >>> shift_amt) + acc_t'(in_block.man[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (in_fire) begin
        if (count == CNT_W'(IN_DEPTH - 1)) begin
          count <= '0;
          out_valid <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      // First block of a run loads directly
      for (int i = 0; i < BLOCK_OUT; i++) begin
        acc_man[i] <= (count == '0) ? acc_t'(in_block.man[i]) : next_man[i];
      end
      acc_exp <= (count == '0) ? in_block.exp : next_exp;
    end
  end

  always_comb begin
    acc.exp = acc_exp;
    for (int i = 0; i < BLOCK_OUT; i++) begin
      acc.man[i] = sum_t'(acc_man[i]);
    end
  end

endmodule

`default_nettype wire

// ==== src/mxint_cast.sv ====
// MXINT output cast
// Picks the smallest right shift that brings every mantissa of the block
// into the output width, shifts them and raises the exponent by the same
// amount. One register stage with valid/ready handshake.
`default_nettype none

module mxint_cast (
  input  wire                        clk,
  input  wire                        reset,
  input  wire mxint_pkg::acc_block_t in_block,
  input  wire                        in_valid,
  output logic                       in_ready,
  output mxint_pkg::out_block_t      out_block,
  output logic                       out_valid,
  input  wire                        out_ready
);

  import mxint_pkg::*;

  localparam int MAX_SHIFT = SUM_WIDTH - OUT_MAN_WIDTH;
  localparam int SHIFT_W = $clog2(MAX_SHIFT + 1);

  logic [SHIFT_W-1:0] shift;
  logic all_fit;
  out_block_t cast_block;

  // True when v is a sign extension of its low OUT_MAN_WIDTH bits
  function automatic logic fits_out(input sum_t v);
    return (&v[SUM_WIDTH-1:OUT_MAN_WIDTH-1]) || !(|v[SUM_WIDTH-1:OUT_MAN_WIDTH-1]);
  endfunction

  // Search downward so the smallest fitting shift wins
  always_comb begin
    shift = SHIFT_W'(MAX_SHIFT);
    all_fit = 1'b0;
    for (int s = MAX_SHIFT; s >= 0; s--) begin
      all_fit = 1'b1;
      for (int i = 0; i < BLOCK_OUT; i++) begin
        all_fit = all_fit && fits_out(in_block.man[i] >>> s);
      end
      if (all_fit) begin
        shift = SHIFT_W'(s);
      end
    end
  end

  always_comb begin
    cast_block.exp = out_exp_t'(in_block.exp) + out_exp_t'(shift);
    for (int i = 0; i < BLOCK_OUT; i++) begin
      cast_block.man[i] = out_man_t'(in_block.man[i] >>> shift);
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_block <= cast_block;
    end
  end

endmodule

`default_nettype wire

// ==== src/mxint_linear.sv ====
// MXINT linear layer, out = x * W^T + bias
// Replay buffers feed two dot products and a block accumulator. The bias
// is aligned to the accumulator exponent and added, then the block is cast
// down to the output mantissa width.
`default_nettype none

module mxint_linear #(
  parameter int IN_FEATURES = 8,
  parameter int OUT_FEATURES = 4,
  parameter int BATCH = 1
) (
  input  wire                           clk,
  input  wire                           reset,
  input  wire mxint_pkg::data_block_t   data_in,
  input  wire                           data_in_valid,
  output logic                          data_in_ready,
  input  wire mxint_pkg::weight_block_t weight_in,
  input  wire                           weight_in_valid,
  output logic                          weight_in_ready,
  input  wire mxint_pkg::bias_block_t   bias_in,
  input  wire                           bias_in_valid,
  output logic                          bias_in_ready,
  output mxint_pkg::out_block_t         data_out,
  output logic                          data_out_valid,
  input  wire                           data_out_ready
);

  import mxint_pkg::*;

  localparam int IN_DEPTH = IN_FEATURES / BLOCK_IN;
  localparam int OUT_DEPTH = OUT_FEATURES / BLOCK_OUT;

  data_block_t buf_data;
  weight_block_t buf_weight;
  bias_block_t buf_bias;
  logic buf_data_valid, buf_data_ready;
  logic buf_weight_valid, buf_weight_ready;
  logic buf_bias_valid, buf_bias_ready;

  logic dp_in_valid;
  logic [BLOCK_OUT-1:0] dp_in_ready, dp_out_valid;
  prod_t dp_man [BLOCK_OUT];
  acc_exp_t dp_exp [BLOCK_OUT];

  prod_block_t acc_in;
  logic acc_in_valid, acc_in_ready;
  acc_block_t acc_out;
  logic acc_out_valid, acc_out_ready;

  logic signed [ACC_EXP_WIDTH:0] bias_diff;
  logic [ACC_EXP_WIDTH:0] bias_amt;
  sum_t bias_aligned [BLOCK_OUT];
  acc_block_t cast_in;
  logic cast_in_valid, cast_in_ready;

  // One row replayed once per output block
  mxint_circular #(.BUFFER_SIZE(IN_DEPTH), .REPEAT(OUT_DEPTH), .block_t(data_block_t))
    data_buffer (.clk, .reset, .in_block(data_in), .in_valid(data_in_valid),
                 .in_ready(data_in_ready), .out_block(buf_data),
                 .out_valid(buf_data_valid), .out_ready(buf_data_ready));

  mxint_circular #(.BUFFER_SIZE(IN_DEPTH * OUT_DEPTH), .REPEAT(BATCH),
                   .block_t(weight_block_t))
    weight_buffer (.clk, .reset, .in_block(weight_in), .in_valid(weight_in_valid),
                   .in_ready(weight_in_ready), .out_block(buf_weight),
                   .out_valid(buf_weight_valid), .out_ready(buf_weight_ready));

  mxint_circular #(.BUFFER_SIZE(OUT_DEPTH), .REPEAT(BATCH), .block_t(bias_block_t))
    bias_buffer (.clk, .reset, .in_block(bias_in), .in_valid(bias_in_valid),
                 .in_ready(bias_in_ready), .out_block(buf_bias),
                 .out_valid(buf_bias_valid), .out_ready(buf_bias_ready));

  // Join data and weight streams into the dot products
  assign dp_in_valid = buf_data_valid && buf_weight_valid;
  assign buf_data_ready = dp_in_valid && (&dp_in_ready);
  assign buf_weight_ready = buf_data_ready;

  for (genvar j = 0; j < BLOCK_OUT; j++) begin : g_dot
    mxint_dot_product dot_product_i (
      .clk, .reset, .data(buf_data), .weight_row(buf_weight.man[j]),
      .weight_exp(buf_weight.exp), .in_valid(dp_in_valid), .in_ready(dp_in_ready[j]),
      .product(dp_man[j]), .product_exp(dp_exp[j]), .out_valid(dp_out_valid[j]),
      .out_ready(acc_in_ready));
  end

  // Both lanes run in lockstep and share one exponent
  assign acc_in_valid = &dp_out_valid;
  always_comb begin
    acc_in.exp = dp_exp[0];
    for (int j = 0; j < BLOCK_OUT; j++) begin
      acc_in.man[j] = dp_man[j];
    end
  end

  mxint_accumulator #(.IN_DEPTH(IN_DEPTH)) accumulator_i (
    .clk, .reset, .in_block(acc_in), .in_valid(acc_in_valid), .in_ready(acc_in_ready),
    .acc(acc_out), .out_valid(acc_out_valid), .out_ready(acc_out_ready));

  // Join accumulator result with its bias block
  assign cast_in_valid = acc_out_valid && buf_bias_valid;
  assign acc_out_ready = cast_in_valid && cast_in_ready;
  assign buf_bias_ready = acc_out_ready;

  // Bias moves to the accumulator exponent, left or right
  always_comb begin
    bias_diff = $signed(buf_bias.exp) - $signed(acc_out.exp);
    bias_amt = bias_diff[ACC_EXP_WIDTH] ? -bias_diff : bias_diff;
    cast_in.exp = acc_out.exp;
    for (int i = 0; i < BLOCK_OUT; i++) begin
      if (bias_diff[ACC_EXP_WIDTH]) begin
        bias_aligned[i] = sum_t'(buf_bias.man[i]) >>> bias_amt;
      end else begin
        bias_aligned[i] = sum_t'(buf_bias.man[i]) <<< bias_amt;
      end
      cast_in.man[i] = acc_out.man[i] + bias_aligned[i];
    end
  end

  mxint_cast cast_i (
    .clk, .reset, .in_block(cast_in), .in_valid(cast_in_valid), .in_ready(cast_in_ready),
    .out_block(data_out), .out_valid(data_out_valid), .out_ready(data_out_ready));

endmodule

`default_nettype wire

// ==== test/mxint_linear_model.svh ====
// MXINT linear layer reference model
// Integer rules for the dot product, block accumulation, bias alignment and
// output cast. Values are carried as longint and wrapped to the hardware
// widths wherever a result is stored.
`ifndef MXINT_LINEAR_MODEL_SVH
`define MXINT_LINEAR_MODEL_SVH

// Keep the low w bits of v as a signed value
function automatic longint sign_extend(input longint v, input int w);
  return (v <<< (64 - w)) >>> (64 - w);
endfunction

// Arithmetic right shift, rounds toward minus infinity
function automatic longint shift_right(input longint v, input int s);
  if (s > 62) begin
    return (v < 0) ? -64'sd1 : 64'sd0;
  end
  return v >>> s;
endfunction

// Both output features of one data block against one weight block
function automatic prod_block_t dot_block(input data_block_t d, input weight_block_t w);
  prod_block_t p;
  longint s;
  for (int j = 0; j < BLOCK_OUT; j++) begin
    s = 0;
    for (int i = 0; i < BLOCK_IN; i++) begin
      s += longint'($signed(d.man[i])) * longint'($signed(w.man[j][i]));
    end
    p.man[j] = prod_t'(sign_extend(s, PROD_WIDTH));
  end
  p.exp = acc_exp_t'(int'($signed(d.exp)) + int'($signed(w.exp)));
  return p;
endfunction

// First block of a run starts the partial sum
function automatic acc_block_t first_partial(input prod_block_t p);
  acc_block_t a;
  for (int j = 0; j < BLOCK_OUT; j++) begin
    a.man[j] = sum_t'($signed(p.man[j]));
  end
  a.exp = p.exp;
  return a;
endfunction

// Larger exponent wins, the other side is shifted down before the add
function automatic acc_block_t merge_partial(input acc_block_t a, input prod_block_t p);
  acc_block_t r;
  int d;
  longint ma;
  longint mp;
  d = int'($signed(p.exp)) - int'($signed(a.exp));
  r.exp = (d < 0) ? a.exp : p.exp;
  for (int j = 0; j < BLOCK_OUT; j++) begin
    ma = longint'($signed(a.man[j]));
    mp = longint'($signed(p.man[j]));
    if (d < 0) begin
      mp = shift_right(mp, -d);
    end else begin
      ma = shift_right(ma, d);
    end
    r.man[j] = sum_t'(sign_extend(ma + mp, ACC_WIDTH));
  end
  return r;
endfunction

// Bias moved to the accumulator exponent, then added
function automatic acc_block_t add_bias(input acc_block_t a, input bias_block_t b);
  acc_block_t r;
  int d;
  longint mb;
  d = int'($signed(b.exp)) - int'($signed(a.exp));
  r.exp = a.exp;
  for (int j = 0; j < BLOCK_OUT; j++) begin
    mb = longint'($signed(b.man[j]));
    mb = (d < 0) ? shift_right(mb, -d) : sign_extend(mb <<< d, SUM_WIDTH);
    r.man[j] = sum_t'(sign_extend(longint'($signed(a.man[j])) + mb, SUM_WIDTH));
  end
  return r;
endfunction

function automatic bit fits_output(input acc_block_t a, input int s);
  longint v;
  longint lim;
  lim = 64'sd1 <<< (OUT_MAN_WIDTH - 1);
  for (int j = 0; j < BLOCK_OUT; j++) begin
    v = shift_right(longint'($signed(a.man[j])), s);
    if (v < -lim || v >= lim) begin
      return 1'b0;
    end
  end
  return 1'b1;
endfunction

// Smallest shift that fits every mantissa, exponent raised to match
function automatic out_block_t narrow_block(input acc_block_t a);
  out_block_t o;
  int s;
  s = 0;
  while (s < SUM_WIDTH - OUT_MAN_WIDTH && !fits_output(a, s)) begin
    s++;
  end
  for (int j = 0; j < BLOCK_OUT; j++) begin
    o.man[j] = out_man_t'(shift_right(longint'($signed(a.man[j])), s));
  end
  o.exp = out_exp_t'(int'($signed(a.exp)) + s);
  return o;
endfunction

`endif

// ==== test/tb_mxint_linear.sv ====
// Testbench for the MXINT linear layer
// Directed tests load weights and bias, stream batch rows and compare every
// data_out block with a reference model. A watchdog bounds the run.
`default_nettype none

module tb_mxint_linear;

  import mxint_pkg::*;

  `include "mxint_linear_model.svh"

  localparam int IN_FEATURES = 8;
  localparam int OUT_FEATURES = 4;
  localparam int BATCH = 3;
  localparam int IN_DEPTH = IN_FEATURES / BLOCK_IN;
  localparam int OUT_DEPTH = OUT_FEATURES / BLOCK_OUT;
  localparam int W_BLOCKS = IN_DEPTH * OUT_DEPTH;
  localparam int NUM_TESTS = 6;
  localparam int DRIVE_DELAY = 10;
  localparam int RAND_SEED = 53;
  // Transfers on all four streams over every test
  localparam int TRANSFERS =
    NUM_TESTS * (BATCH * IN_DEPTH + W_BLOCKS + OUT_DEPTH + BATCH * OUT_DEPTH);
  localparam int TIMEOUT = 4 * TRANSFERS * 200;

  logic clk;
  logic reset;
  data_block_t data_in;
  logic data_in_valid;
  logic data_in_ready;
  weight_block_t weight_in;
  logic weight_in_valid;
  logic weight_in_ready;
  bias_block_t bias_in;
  logic bias_in_valid;
  logic bias_in_ready;
  out_block_t data_out;
  logic data_out_valid;
  logic data_out_ready;

  data_block_t row_blk [BATCH][IN_DEPTH];
  weight_block_t w_blk [W_BLOCKS];
  bias_block_t b_blk [OUT_DEPTH];
  out_block_t expected_q [$];
  out_block_t want;
  bit use_gaps;
  bit use_stalls;
  int error_count;
  int check_count;
  int received_count;
  int test_count;

  mxint_linear #(.IN_FEATURES(IN_FEATURES), .OUT_FEATURES(OUT_FEATURES), .BATCH(BATCH))
    mxint_linear_i (
      .clk, .reset, .data_in, .data_in_valid, .data_in_ready,
      .weight_in, .weight_in_valid, .weight_in_ready,
      .bias_in, .bias_in_valid, .bias_in_ready,
      .data_out, .data_out_valid, .data_out_ready);

  always #50 clk = ~clk;

  // Random output back-pressure while stalls are on
  always @(posedge clk) begin
    #DRIVE_DELAY;
    data_out_ready = use_stalls ? ($urandom_range(3) != 0) : 1'b1;
  end

  // Scoreboard sampled mid-cycle where handshake and payload are stable
  always @(negedge clk) begin
    if (!reset && data_out_valid && data_out_ready) begin
      if (expected_q.size() == 0) begin
        $display("data_out delivered block %h with no result pending", data_out);
        error_count++;
      end else begin
        want = expected_q.pop_front();
        check_count++;
        if (data_out.exp !== want.exp) begin
          $display("MISMATCH data_out.exp: expected %h, got %h (block %0d)",
                   want.exp, data_out.exp, received_count);
          error_count++;
        end
        for (int j = 0; j < BLOCK_OUT; j++) begin
          if (data_out.man[j] !== want.man[j]) begin
            $display("MISMATCH data_out.man[%0d]: expected %h, got %h (block %0d)",
                     j, want.man[j], data_out.man[j], received_count);
            error_count++;
          end
        end
      end
      received_count++;
    end
  end

  function automatic int rand_int(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  // Random idle cycles before a transfer
  task automatic idle_gap();
    int n;
    n = use_gaps ? int'($urandom_range(2)) : 0;
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic drive_weights();
    for (int b = 0; b < W_BLOCKS; b++) begin
      idle_gap();
      weight_in = w_blk[b];
      weight_in_valid = 1'b1;
      @(negedge clk);
      while (!weight_in_ready) @(negedge clk);
      @(posedge clk);
      #DRIVE_DELAY;
      weight_in_valid = 1'b0;
    end
  endtask

  task automatic drive_bias();
    for (int b = 0; b < OUT_DEPTH; b++) begin
      idle_gap();
      bias_in = b_blk[b];
      bias_in_valid = 1'b1;
      @(negedge clk);
      while (!bias_in_ready) @(negedge clk);
      @(posedge clk);
      #DRIVE_DELAY;
      bias_in_valid = 1'b0;
    end
  endtask

  task automatic drive_rows();
    for (int r = 0; r < BATCH; r++) begin
      for (int k = 0; k < IN_DEPTH; k++) begin
        idle_gap();
        data_in = row_blk[r][k];
        data_in_valid = 1'b1;
        @(negedge clk);
        while (!data_in_ready) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        data_in_valid = 1'b0;
      end
    end
  endtask

  // Mantissas in [lo, hi] and exponents from the given ranges
  task automatic fill_random(input int lo, input int hi, input int de_lo, input int de_hi,
                             input int we_lo, input int we_hi, input int be_lo,
                             input int be_hi);
    for (int r = 0; r < BATCH; r++) begin
      for (int k = 0; k < IN_DEPTH; k++) begin
        row_blk[r][k].exp = exp_t'(rand_int(de_lo, de_hi));
        for (int i = 0; i < BLOCK_IN; i++) begin
          row_blk[r][k].man[i] = man_t'(rand_int(lo, hi));
        end
      end
    end
    for (int b = 0; b < W_BLOCKS; b++) begin
      w_blk[b].exp = exp_t'(rand_int(we_lo, we_hi));
      for (int j = 0; j < BLOCK_OUT; j++) begin
        for (int i = 0; i < BLOCK_IN; i++) begin
          w_blk[b].man[j][i] = man_t'(rand_int(lo, hi));
        end
      end
    end
    for (int b = 0; b < OUT_DEPTH; b++) begin
      b_blk[b].exp = exp_t'(rand_int(be_lo, be_hi));
      for (int j = 0; j < BLOCK_OUT; j++) begin
        b_blk[b].man[j] = man_t'(rand_int(lo, hi));
      end
    end
  endtask

  // Expected results in hardware order before one full batch through the DUT
  task automatic run_batch(input string name);
    acc_block_t acc;
    int target;
    int errors_before;
    errors_before = error_count;
    for (int r = 0; r < BATCH; r++) begin
      for (int j = 0; j < OUT_DEPTH; j++) begin
        acc = first_partial(dot_block(row_blk[r][0], w_blk[j * IN_DEPTH]));
        for (int k = 1; k < IN_DEPTH; k++) begin
          acc = merge_partial(acc, dot_block(row_blk[r][k], w_blk[j * IN_DEPTH + k]));
        end
        expected_q.push_back(narrow_block(add_bias(acc, b_blk[j])));
      end
    end
    target = received_count + BATCH * OUT_DEPTH;
    fork
      drive_weights();
      drive_bias();
      drive_rows();
    join
    wait (received_count >= target);
    test_count++;
    $display("test %0d %s: %0d blocks, %0d errors", test_count, name,
             BATCH * OUT_DEPTH, error_count - errors_before);
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic test_equal_exponents();
    fill_random(-3, 3, 0, 0, 0, 0, 0, 0);
    run_batch("equal exponents");
  endtask

  task automatic test_mixed_exponents();
    fill_random(-40, 40, -6, 6, -6, 6, -2, 2);
    run_batch("mixed exponents");
  endtask

  task automatic test_large_mantissas();
    fill_random(-128, 127, 0, 2, 0, 2, 0, 2);
    run_batch("large mantissas");
  endtask

  task automatic test_bias_alignment();
    // Small sums keep the cast shift low so both bias alignments stay visible
    fill_random(-12, 12, 0, 1, 0, 1, 0, 0);
    // Block 0 sits above the accumulator exponent and block 1 below it
    b_blk[0].exp = exp_t'(6);
    b_blk[1].exp = exp_t'(-2);
    run_batch("bias alignment");
  endtask

  task automatic test_backpressure();
    use_gaps = 1'b1;
    use_stalls = 1'b1;
    fill_random(-128, 127, -4, 4, -4, 4, -4, 4);
    run_batch("back-pressure and gaps");
    use_gaps = 1'b0;
    use_stalls = 1'b0;
  endtask

  task automatic test_reload();
    if (!(data_in_ready && weight_in_ready && bias_in_ready)) begin
      $display("buffers did not return to the fill state after a full batch");
      error_count++;
    end
    fill_random(-60, 60, -3, 3, 2, 5, -2, 2);
    run_batch("second load");
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    clk = 1'b0;
    reset = 1'b1;
    data_in = '0;
    data_in_valid = 1'b0;
    weight_in = '0;
    weight_in_valid = 1'b0;
    bias_in = '0;
    bias_in_valid = 1'b0;
    data_out_ready = 1'b1;
    use_gaps = 1'b0;
    use_stalls = 1'b0;
    error_count = 0;
    check_count = 0;
    received_count = 0;
    test_count = 0;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    test_equal_exponents();
    test_mixed_exponents();
    test_large_mantissas();
    test_bias_alignment();
    test_backpressure();
    test_reload();
    // Quiet time to catch a repeated or stray output block
    repeat (20) @(posedge clk);
    $display("summary: %0d tests, %0d blocks checked, %0d errors",
             test_count, check_count, error_count);
    if (error_count == 0 && expected_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("timeout after %0d time units, results stopped arriving", TIMEOUT);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+test
common/mxint_pkg.sv
src/mxint_circular.sv
src/mxint_dot_product.sv
src/mxint_accumulator.sv
src/mxint_cast.sv
src/mxint_linear.sv
test/tb_mxint_linear.sv
